// File: logic/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

`define MIPS_OPC_W      6
`define MIPS_FN_W       6
`define MIPS_REG_W      5
`define MIPS_SHAMT_W    5

`define MIPS_OPC_SPECIAL    6'h00
`define MIPS_OPC_REGIMM     6'h01
`define MIPS_OPC_J          6'h02
`define MIPS_OPC_JAL        6'h03
`define MIPS_OPC_BEQ        6'h04
`define MIPS_OPC_BNE        6'h05
`define MIPS_OPC_BLEZ       6'h06
`define MIPS_OPC_BGTZ       6'h07
`define MIPS_OPC_ADDI       6'h08
`define MIPS_OPC_ADDIU      6'h09
`define MIPS_OPC_SLTI       6'h0a
`define MIPS_OPC_SLTIU      6'h0b
`define MIPS_OPC_ANDI       6'h0c
`define MIPS_OPC_ORI        6'h0d
`define MIPS_OPC_XORI       6'h0e
`define MIPS_OPC_LUI        6'h0f
`define MIPS_OPC_COP0       6'h10
`define MIPS_OPC_SPECIAL2   6'h1c
`define MIPS_OPC_LB         6'h20
`define MIPS_OPC_LH         6'h21
`define MIPS_OPC_LW         6'h23
`define MIPS_OPC_LBU        6'h24
`define MIPS_OPC_LHU        6'h25
`define MIPS_OPC_SB         6'h28
`define MIPS_OPC_SH         6'h29
`define MIPS_OPC_SW         6'h2b

// rt field selects the REGIMM branch
`define MIPS_RT_BLTZ    5'h00
`define MIPS_RT_BGEZ    5'h01

`define MIPS_FN_SLL     6'h00
`define MIPS_FN_SRL     6'h02
`define MIPS_FN_SRA     6'h03
`define MIPS_FN_SLLV    6'h04
`define MIPS_FN_SRLV    6'h06
`define MIPS_FN_SRAV    6'h07
`define MIPS_FN_JR      6'h08
`define MIPS_FN_JALR    6'h09
`define MIPS_FN_MOVZ    6'h0a
`define MIPS_FN_MOVN    6'h0b
`define MIPS_FN_MFHI    6'h10
`define MIPS_FN_MTHI    6'h11
`define MIPS_FN_MFLO    6'h12
`define MIPS_FN_MTLO    6'h13
`define MIPS_FN_MULT    6'h18
`define MIPS_FN_MULTU   6'h19
`define MIPS_FN_DIV     6'h1a
`define MIPS_FN_DIVU    6'h1b
`define MIPS_FN_ADD     6'h20
`define MIPS_FN_ADDU    6'h21
`define MIPS_FN_SUB     6'h22
`define MIPS_FN_SUBU    6'h23
`define MIPS_FN_AND     6'h24
`define MIPS_FN_OR      6'h25
`define MIPS_FN_XOR     6'h26
`define MIPS_FN_NOR     6'h27
`define MIPS_FN_SLT     6'h2a
`define MIPS_FN_SLTU    6'h2b

// special2 funct space
`define MIPS_FN_MADD    6'h00
`define MIPS_FN_MADDU   6'h01
`define MIPS_FN_MUL     6'h02
`define MIPS_FN_MSUB    6'h04
`define MIPS_FN_MSUBU   6'h05
`define MIPS_FN_CLZ     6'h20
`define MIPS_FN_CLO     6'h21

`define MIPS_RA         5'd31

`endif

// File: logic/mips_pkg.sv
`include "mips_consts.svh"

package mips_pkg;

    typedef logic [`MIPS_REG_W-1:0]   reg_idx_t;
    typedef logic [`MIPS_SHAMT_W-1:0] shamt_t;
    typedef logic [`MIPS_OPC_W-1:0]   opc_t;
    typedef logic [`MIPS_FN_W-1:0]    funct_t;

    typedef enum logic [7:0] {
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLLV,
        OP_SRLV,
        OP_SRAV,
        OP_JR,
        OP_JALR,
        OP_MOVZ,
        OP_MOVN,
        OP_MFHI,
        OP_MTHI,
        OP_MFLO,
        OP_MTLO,
        OP_MULT,
        OP_DIV,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOR,
        OP_SLT,
        OP_MFC0,
        OP_MADD,
        OP_MUL,
        OP_MSUB,
        OP_CLZ,
        OP_CLO,
        OP_ADDI,
        OP_SLTI,
        OP_ANDI,
        OP_ORI,
        OP_XORI,
        OP_LUI,
        OP_LB,
        OP_LBU,
        OP_LH,
        OP_LHU,
        OP_LW,
        OP_SB,
        OP_SH,
        OP_SW,
        OP_BEQ,
        OP_BNE,
        OP_BLEZ,
        OP_BGTZ,
        OP_BLTZ,
        OP_BGEZ,
        OP_J,
        OP_JAL,
        OP_INVALID = 8'hff
    } op_e;

endpackage

// File: logic/decode_if.sv
`timescale 1ns/1ps

interface decode_if;

    mips_pkg::op_e      op;
    mips_pkg::reg_idx_t reg_s;
    mips_pkg::reg_idx_t reg_t;
    mips_pkg::reg_idx_t reg_d;
    mips_pkg::shamt_t   shift;
    logic [31:0]        imm;
    logic               flag_unsigned;

    modport producer (
        output op,
        output reg_s,
        output reg_t,
        output reg_d,
        output shift,
        output imm,
        output flag_unsigned
    );

    modport consumer (
        input op,
        input reg_s,
        input reg_t,
        input reg_d,
        input shift,
        input imm,
        input flag_unsigned
    );

endinterface

// File: logic/id_r.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module id_r (
    input  logic [31:0] inst,
    decode_if.producer  dec
);

    mips_pkg::opc_t   opc;
    mips_pkg::funct_t fn;

    assign opc = inst[31:26];
    assign fn  = inst[5:0];

    assign dec.reg_s = inst[25:21];
    assign dec.reg_t = inst[20:16];
    assign dec.reg_d = inst[15:11];
    assign dec.shift = inst[10:6];
    assign dec.imm   = '0;

    // funct only, opcode not checked
    assign dec.flag_unsigned = (fn == `MIPS_FN_ADDU)  ||
                               (fn == `MIPS_FN_SLTU)  ||
                               (fn == `MIPS_FN_SUBU)  ||
                               (fn == `MIPS_FN_DIVU)  ||
                               (fn == `MIPS_FN_MULTU) ||
                               (fn == `MIPS_FN_MADDU) ||
                               (fn == `MIPS_FN_MSUBU);

    always_comb begin
        case (opc)
            `MIPS_OPC_SPECIAL: begin
                case (fn)
                    `MIPS_FN_SLL:                  dec.op = mips_pkg::OP_SLL;
                    `MIPS_FN_SRL:                  dec.op = mips_pkg::OP_SRL;
                    `MIPS_FN_SRA:                  dec.op = mips_pkg::OP_SRA;
                    `MIPS_FN_SLLV:                 dec.op = mips_pkg::OP_SLLV;
                    `MIPS_FN_SRLV:                 dec.op = mips_pkg::OP_SRLV;
                    `MIPS_FN_SRAV:                 dec.op = mips_pkg::OP_SRAV;
                    `MIPS_FN_JR:                   dec.op = mips_pkg::OP_JR;
                    `MIPS_FN_JALR:                 dec.op = mips_pkg::OP_JALR;
                    `MIPS_FN_MOVZ:                 dec.op = mips_pkg::OP_MOVZ;
                    `MIPS_FN_MOVN:                 dec.op = mips_pkg::OP_MOVN;
                    `MIPS_FN_MFHI:                 dec.op = mips_pkg::OP_MFHI;
                    `MIPS_FN_MTHI:                 dec.op = mips_pkg::OP_MTHI;
                    `MIPS_FN_MFLO:                 dec.op = mips_pkg::OP_MFLO;
                    `MIPS_FN_MTLO:                 dec.op = mips_pkg::OP_MTLO;
                    `MIPS_FN_MULT, `MIPS_FN_MULTU: dec.op = mips_pkg::OP_MULT;
                    `MIPS_FN_DIV, `MIPS_FN_DIVU:   dec.op = mips_pkg::OP_DIV;
                    `MIPS_FN_ADD, `MIPS_FN_ADDU:   dec.op = mips_pkg::OP_ADD;
                    `MIPS_FN_SUB, `MIPS_FN_SUBU:   dec.op = mips_pkg::OP_SUB;
                    `MIPS_FN_AND:                  dec.op = mips_pkg::OP_AND;
                    `MIPS_FN_OR:                   dec.op = mips_pkg::OP_OR;
                    `MIPS_FN_XOR:                  dec.op = mips_pkg::OP_XOR;
                    `MIPS_FN_NOR:                  dec.op = mips_pkg::OP_NOR;
                    `MIPS_FN_SLT, `MIPS_FN_SLTU:   dec.op = mips_pkg::OP_SLT;
                    default:                       dec.op = mips_pkg::OP_INVALID;
                endcase
            end
            `MIPS_OPC_COP0: begin
                dec.op = mips_pkg::OP_MFC0;    // rs field not decoded
            end
            `MIPS_OPC_SPECIAL2: begin
                case (fn)
                    `MIPS_FN_MADD, `MIPS_FN_MADDU: dec.op = mips_pkg::OP_MADD;
                    `MIPS_FN_MUL:                  dec.op = mips_pkg::OP_MUL;
                    `MIPS_FN_MSUB, `MIPS_FN_MSUBU: dec.op = mips_pkg::OP_MSUB;
                    `MIPS_FN_CLZ:                  dec.op = mips_pkg::OP_CLZ;
                    `MIPS_FN_CLO:                  dec.op = mips_pkg::OP_CLO;
                    default:                       dec.op = mips_pkg::OP_INVALID;
                endcase
            end
            default: begin
                dec.op = mips_pkg::OP_INVALID;    // left to id_i
            end
        endcase
    end

    always_comb begin
        if (!$isunknown(inst)) begin
            a_op_known: assert final (!$isunknown(dec.op))
                else $error("id_r: op unknown for inst %h", inst);
        end
    end

endmodule

// File: logic/id_i.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module id_i (
    input  logic [31:0] inst,
    decode_if.producer  dec
);

    mips_pkg::opc_t     opc;
    mips_pkg::reg_idx_t rt;
    logic [15:0]        imm16;
    logic [31:0]        imm_sext;

    assign opc      = inst[31:26];
    assign rt       = inst[20:16];
    assign imm16    = inst[15:0];
    assign imm_sext = {{16{imm16[15]}}, imm16};

    assign dec.reg_s = inst[25:21];
    assign dec.reg_t = rt;
    assign dec.shift = '0;

    always_comb begin
        dec.op            = mips_pkg::OP_INVALID;
        dec.reg_d         = '0;               // stores, branches, j
        dec.imm           = imm_sext;
        dec.flag_unsigned = 1'b0;
        case (opc)
            `MIPS_OPC_ADDI, `MIPS_OPC_ADDIU: begin
                dec.op            = mips_pkg::OP_ADDI;
                dec.reg_d         = rt;
                dec.flag_unsigned = (opc == `MIPS_OPC_ADDIU);
            end
            `MIPS_OPC_SLTI, `MIPS_OPC_SLTIU: begin
                dec.op            = mips_pkg::OP_SLTI;
                dec.reg_d         = rt;
                dec.flag_unsigned = (opc == `MIPS_OPC_SLTIU);
            end
            `MIPS_OPC_ANDI: begin
                dec.op    = mips_pkg::OP_ANDI;
                dec.reg_d = rt;
                dec.imm   = {16'h0000, imm16};    // logic ops zero extend
            end
            `MIPS_OPC_ORI: begin
                dec.op    = mips_pkg::OP_ORI;
                dec.reg_d = rt;
                dec.imm   = {16'h0000, imm16};
            end
            `MIPS_OPC_XORI: begin
                dec.op    = mips_pkg::OP_XORI;
                dec.reg_d = rt;
                dec.imm   = {16'h0000, imm16};
            end
            `MIPS_OPC_LUI: begin
                dec.op    = mips_pkg::OP_LUI;
                dec.reg_d = rt;
                dec.imm   = {imm16, 16'h0000};
            end
            `MIPS_OPC_LB: begin
                dec.op    = mips_pkg::OP_LB;
                dec.reg_d = rt;
            end
            `MIPS_OPC_LBU: begin
                dec.op            = mips_pkg::OP_LBU;
                dec.reg_d         = rt;
                dec.flag_unsigned = 1'b1;
            end
            `MIPS_OPC_LH: begin
                dec.op    = mips_pkg::OP_LH;
                dec.reg_d = rt;
            end
            `MIPS_OPC_LHU: begin
                dec.op            = mips_pkg::OP_LHU;
                dec.reg_d         = rt;
                dec.flag_unsigned = 1'b1;
            end
            `MIPS_OPC_LW: begin
                dec.op    = mips_pkg::OP_LW;
                dec.reg_d = rt;
            end
            `MIPS_OPC_SB:   dec.op = mips_pkg::OP_SB;
            `MIPS_OPC_SH:   dec.op = mips_pkg::OP_SH;
            `MIPS_OPC_SW:   dec.op = mips_pkg::OP_SW;
            `MIPS_OPC_BEQ:  dec.op = mips_pkg::OP_BEQ;
            `MIPS_OPC_BNE:  dec.op = mips_pkg::OP_BNE;
            `MIPS_OPC_BLEZ: dec.op = mips_pkg::OP_BLEZ;
            `MIPS_OPC_BGTZ: dec.op = mips_pkg::OP_BGTZ;
            `MIPS_OPC_REGIMM: begin
                case (rt)
                    `MIPS_RT_BLTZ: dec.op = mips_pkg::OP_BLTZ;
                    `MIPS_RT_BGEZ: dec.op = mips_pkg::OP_BGEZ;
                    default:       dec.op = mips_pkg::OP_INVALID;
                endcase
            end
            `MIPS_OPC_J: begin
                dec.op  = mips_pkg::OP_J;
                dec.imm = {6'b000000, inst[25:0]};    // word target, no shift here
            end
            `MIPS_OPC_JAL: begin
                dec.op    = mips_pkg::OP_JAL;
                dec.reg_d = `MIPS_RA;
                dec.imm   = {6'b000000, inst[25:0]};
            end
            default: begin
                dec.op = mips_pkg::OP_INVALID;    // special, special2, cop0, unused
            end
        endcase
    end

endmodule

// File: logic/id_merge.sv
`timescale 1ns/1ps

module id_merge (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               inst_valid,
    decode_if.consumer         r_dec,
    decode_if.consumer         i_dec,
    output logic               dec_valid,
    output mips_pkg::op_e      op,
    output mips_pkg::reg_idx_t reg_s,
    output mips_pkg::reg_idx_t reg_t,
    output mips_pkg::reg_idx_t reg_d,
    output mips_pkg::shamt_t   shift,
    output logic [31:0]        imm,
    output logic               flag_unsigned,
    output logic               illegal
);

    logic r_legal;
    logic i_legal;
    logic use_i;

    assign r_legal = (r_dec.op != mips_pkg::OP_INVALID);
    assign i_legal = (i_dec.op != mips_pkg::OP_INVALID);
    assign use_i   = i_legal;    // r side when neither is legal

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
            illegal   <= 1'b0;
            op        <= mips_pkg::OP_INVALID;
        end else begin
            dec_valid <= inst_valid;    // one pulse per sampled word
            if (inst_valid) begin
                op      <= use_i ? i_dec.op : r_dec.op;
                illegal <= !r_legal && !i_legal;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            reg_s         <= use_i ? i_dec.reg_s : r_dec.reg_s;
            reg_t         <= use_i ? i_dec.reg_t : r_dec.reg_t;
            reg_d         <= use_i ? i_dec.reg_d : r_dec.reg_d;
            shift         <= use_i ? i_dec.shift : r_dec.shift;
            imm           <= use_i ? i_dec.imm : r_dec.imm;
            flag_unsigned <= use_i ? i_dec.flag_unsigned : r_dec.flag_unsigned;
        end
    end

    // opcode sets of the two decoders must not overlap
    a_one_legal: assert property (@(posedge clk) disable iff (!arst_n)
        inst_valid |-> !(r_legal && i_legal))
        else $error("id_merge: both decoders legal");

    a_illegal_op: assert property (@(posedge clk) disable iff (!arst_n)
        illegal |-> (op == mips_pkg::OP_INVALID))
        else $error("id_merge: illegal set with op %h", op);

endmodule

// File: logic/id_stage.sv
`timescale 1ns/1ps

module id_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               inst_valid,
    input  logic [31:0]        inst,
    output logic               dec_valid,
    output mips_pkg::op_e      op,
    output mips_pkg::reg_idx_t reg_s,
    output mips_pkg::reg_idx_t reg_t,
    output mips_pkg::reg_idx_t reg_d,
    output mips_pkg::shamt_t   shift,
    output logic [31:0]        imm,
    output logic               flag_unsigned,
    output logic               illegal
);

    decode_if r_dec ();
    decode_if i_dec ();

    id_r u_id_r (
        .inst (inst),
        .dec  (r_dec.producer)
    );

    id_i u_id_i (
        .inst (inst),
        .dec  (i_dec.producer)
    );

    id_merge u_id_merge (
        .clk           (clk),
        .arst_n        (arst_n),
        .inst_valid    (inst_valid),
        .r_dec         (r_dec.consumer),
        .i_dec         (i_dec.consumer),
        .dec_valid     (dec_valid),
        .op            (op),
        .reg_s         (reg_s),
        .reg_t         (reg_t),
        .reg_d         (reg_d),
        .shift         (shift),
        .imm           (imm),
        .flag_unsigned (flag_unsigned),
        .illegal       (illegal)
    );

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

// File: test/id_stage_tb.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module id_stage_tb;

    localparam int N_WORDS   = 36 + 48 + 11 + 16 + 2;
    localparam int LIMIT_CYC = N_WORDS * 20 + 8;

    // special 0..27, special2 28..34, cop0 at 35
    localparam logic [5:0] R_FN [36] = '{
        `MIPS_FN_SLL, `MIPS_FN_SRL, `MIPS_FN_SRA, `MIPS_FN_SLLV, `MIPS_FN_SRLV,
        `MIPS_FN_SRAV, `MIPS_FN_JR, `MIPS_FN_JALR, `MIPS_FN_MOVZ, `MIPS_FN_MOVN,
        `MIPS_FN_MFHI, `MIPS_FN_MTHI, `MIPS_FN_MFLO, `MIPS_FN_MTLO, `MIPS_FN_MULT,
        `MIPS_FN_MULTU, `MIPS_FN_DIV, `MIPS_FN_DIVU, `MIPS_FN_ADD, `MIPS_FN_ADDU,
        `MIPS_FN_SUB, `MIPS_FN_SUBU, `MIPS_FN_AND, `MIPS_FN_OR, `MIPS_FN_XOR,
        `MIPS_FN_NOR, `MIPS_FN_SLT, `MIPS_FN_SLTU,
        `MIPS_FN_MADD, `MIPS_FN_MADDU, `MIPS_FN_MUL, `MIPS_FN_MSUB, `MIPS_FN_MSUBU,
        `MIPS_FN_CLZ, `MIPS_FN_CLO, 6'h00
    };
    localparam mips_pkg::op_e R_OP [36] = '{
        mips_pkg::OP_SLL, mips_pkg::OP_SRL, mips_pkg::OP_SRA, mips_pkg::OP_SLLV,
        mips_pkg::OP_SRLV, mips_pkg::OP_SRAV, mips_pkg::OP_JR, mips_pkg::OP_JALR,
        mips_pkg::OP_MOVZ, mips_pkg::OP_MOVN, mips_pkg::OP_MFHI, mips_pkg::OP_MTHI,
        mips_pkg::OP_MFLO, mips_pkg::OP_MTLO, mips_pkg::OP_MULT, mips_pkg::OP_MULT,
        mips_pkg::OP_DIV, mips_pkg::OP_DIV, mips_pkg::OP_ADD, mips_pkg::OP_ADD,
        mips_pkg::OP_SUB, mips_pkg::OP_SUB, mips_pkg::OP_AND, mips_pkg::OP_OR,
        mips_pkg::OP_XOR, mips_pkg::OP_NOR, mips_pkg::OP_SLT, mips_pkg::OP_SLT,
        mips_pkg::OP_MADD, mips_pkg::OP_MADD, mips_pkg::OP_MUL, mips_pkg::OP_MSUB,
        mips_pkg::OP_MSUB, mips_pkg::OP_CLZ, mips_pkg::OP_CLO, mips_pkg::OP_MFC0
    };
    // entries 0..12 write rt
    localparam logic [5:0] I_OPC [24] = '{
        `MIPS_OPC_ADDI, `MIPS_OPC_ADDIU, `MIPS_OPC_SLTI, `MIPS_OPC_SLTIU, `MIPS_OPC_ANDI,
        `MIPS_OPC_ORI, `MIPS_OPC_XORI, `MIPS_OPC_LUI, `MIPS_OPC_LB, `MIPS_OPC_LBU,
        `MIPS_OPC_LH, `MIPS_OPC_LHU, `MIPS_OPC_LW, `MIPS_OPC_SB, `MIPS_OPC_SH,
        `MIPS_OPC_SW, `MIPS_OPC_BEQ, `MIPS_OPC_BNE, `MIPS_OPC_BLEZ, `MIPS_OPC_BGTZ,
        `MIPS_OPC_REGIMM, `MIPS_OPC_REGIMM, `MIPS_OPC_J, `MIPS_OPC_JAL
    };
    localparam mips_pkg::op_e I_OP [24] = '{
        mips_pkg::OP_ADDI, mips_pkg::OP_ADDI, mips_pkg::OP_SLTI, mips_pkg::OP_SLTI,
        mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LUI,
        mips_pkg::OP_LB, mips_pkg::OP_LBU, mips_pkg::OP_LH, mips_pkg::OP_LHU,
        mips_pkg::OP_LW, mips_pkg::OP_SB, mips_pkg::OP_SH, mips_pkg::OP_SW,
        mips_pkg::OP_BEQ, mips_pkg::OP_BNE, mips_pkg::OP_BLEZ, mips_pkg::OP_BGTZ,
        mips_pkg::OP_BLTZ, mips_pkg::OP_BGEZ, mips_pkg::OP_J, mips_pkg::OP_JAL
    };

    logic               clk;
    logic               arst_n;
    logic               inst_valid;
    logic [31:0]        inst;
    logic               dec_valid;
    mips_pkg::op_e      op;
    mips_pkg::reg_idx_t reg_s;
    mips_pkg::reg_idx_t reg_t;
    mips_pkg::reg_idx_t reg_d;
    mips_pkg::shamt_t   shift;
    logic [31:0]        imm;
    logic               flag_unsigned;
    logic               illegal;

    int                 err_count;
    logic [31:0]        word;
    mips_pkg::op_e      exp_op;
    mips_pkg::reg_idx_t exp_rs;
    mips_pkg::reg_idx_t exp_rt;
    mips_pkg::reg_idx_t exp_rd;
    mips_pkg::shamt_t   exp_sh;
    logic [31:0]        exp_imm;
    logic               exp_uns;

    tb_clock #(.PERIOD_NS(8)) u_clock (.clk(clk));

    id_stage uut (
        .clk           (clk),
        .arst_n        (arst_n),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .dec_valid     (dec_valid),
        .op            (op),
        .reg_s         (reg_s),
        .reg_t         (reg_t),
        .reg_d         (reg_d),
        .shift         (shift),
        .imm           (imm),
        .flag_unsigned (flag_unsigned),
        .illegal       (illegal)
    );

    task automatic abort_run();
        err_count++;
        $display("Simulation failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic op_check(input string name, input mips_pkg::op_e got,
                            input mips_pkg::op_e exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic reg_check(input string name, input mips_pkg::reg_idx_t got,
                             input mips_pkg::reg_idx_t exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic word_check(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic bit_check(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic logic unsigned_funct(input logic [5:0] fn);
        return fn inside {`MIPS_FN_ADDU, `MIPS_FN_SLTU, `MIPS_FN_SUBU, `MIPS_FN_DIVU,
                          `MIPS_FN_MULTU, `MIPS_FN_MADDU, `MIPS_FN_MSUBU};
    endfunction

    task automatic fields_check();
        op_check("op", op, exp_op);
        reg_check("reg_s", reg_s, exp_rs);
        reg_check("reg_t", reg_t, exp_rt);
        reg_check("reg_d", reg_d, exp_rd);
        reg_check("shift", shift, exp_sh);
        word_check("imm", imm, exp_imm);
        bit_check("flag_unsigned", flag_unsigned, exp_uns);
        bit_check("illegal", illegal, 1'b0);
    endtask

    task automatic apply_word(input logic [31:0] w);
        @(negedge clk);
        inst       = w;
        inst_valid = 1'b1;
        @(negedge clk);    // sampled at the rising edge in between
        inst_valid = 1'b0;
        bit_check("dec_valid", dec_valid, 1'b1);
    endtask

    task automatic build_r(input int idx);
        logic [31:0] r;
        logic [5:0]  opc;
        r = $urandom();
        if (idx < 28)
            opc = `MIPS_OPC_SPECIAL;
        else if (idx < 35)
            opc = `MIPS_OPC_SPECIAL2;
        else
            opc = `MIPS_OPC_COP0;
        exp_rs  = r[4:0];
        exp_rt  = r[9:5];
        exp_rd  = r[14:10];
        exp_sh  = r[19:15];
        word    = {opc, exp_rs, exp_rt, exp_rd, exp_sh, R_FN[idx]};
        exp_op  = R_OP[idx];
        exp_imm = 32'h0000_0000;
        exp_uns = unsigned_funct(R_FN[idx]);
    endtask

    task automatic build_i(input int idx, input logic top);
        logic [31:0] r;
        logic [5:0]  opc;
        logic [15:0] imm16;
        r      = $urandom();
        opc    = I_OPC[idx];
        imm16  = {top, r[14:0]};
        exp_rs = r[20:16];
        exp_rt = r[25:21];
        if (opc == `MIPS_OPC_REGIMM)
            exp_rt = (I_OP[idx] == mips_pkg::OP_BLTZ) ? `MIPS_RT_BLTZ : `MIPS_RT_BGEZ;
        word    = {opc, exp_rs, exp_rt, imm16};
        exp_op  = I_OP[idx];
        exp_sh  = 5'd0;
        exp_rd  = 5'd0;    // stores, branches, j
        exp_imm = {{16{imm16[15]}}, imm16};
        exp_uns = opc inside {`MIPS_OPC_ADDIU, `MIPS_OPC_SLTIU, `MIPS_OPC_LBU, `MIPS_OPC_LHU};
        if (idx <= 12)
            exp_rd = exp_rt;
        if (opc == `MIPS_OPC_JAL)
            exp_rd = `MIPS_RA;
        if (opc inside {`MIPS_OPC_ANDI, `MIPS_OPC_ORI, `MIPS_OPC_XORI})
            exp_imm = {16'h0000, imm16};
        if (opc == `MIPS_OPC_LUI)
            exp_imm = {imm16, 16'h0000};
        if (opc inside {`MIPS_OPC_J, `MIPS_OPC_JAL})
            exp_imm = {6'b000000, word[25:0]};    // 26-bit target
    endtask

    task automatic reset_state();
        bit_check("dec_valid", dec_valid, 1'b0);
        bit_check("illegal", illegal, 1'b0);
        op_check("op", op, mips_pkg::OP_INVALID);
    endtask

    task automatic rtype_sweep();
        for (int i = 0; i < 36; i++) begin
            build_r(i);
            apply_word(word);
            fields_check();
        end
    endtask

    task automatic itype_sweep();
        for (int s = 0; s < 2; s++) begin
            for (int i = 0; i < 24; i++) begin
                build_i(i, s == 1);    // both immediate signs
                apply_word(word);
                fields_check();
            end
        end
    endtask

    task automatic illegal_words();
        logic [31:0] r;
        logic [31:0] bad [11];
        r       = $urandom();
        bad[0]  = {6'h11, r[25:0]};
        bad[1]  = {6'h1d, r[25:0]};
        bad[2]  = {6'h22, r[25:0]};
        bad[3]  = {6'h3f, r[25:0]};
        bad[4]  = {`MIPS_OPC_SPECIAL, r[25:6], 6'h01};
        bad[5]  = {`MIPS_OPC_SPECIAL, r[25:6], 6'h05};
        bad[6]  = {`MIPS_OPC_SPECIAL, r[25:6], 6'h3f};
        bad[7]  = {`MIPS_OPC_SPECIAL2, r[25:6], 6'h03};
        bad[8]  = {`MIPS_OPC_SPECIAL2, r[25:6], 6'h3f};
        bad[9]  = {`MIPS_OPC_REGIMM, r[25:21], 5'h02, r[15:0]};
        bad[10] = {`MIPS_OPC_REGIMM, r[25:21], 5'h11, r[15:0]};
        for (int i = 0; i < 11; i++) begin
            apply_word(bad[i]);
            op_check("op", op, mips_pkg::OP_INVALID);
            bit_check("illegal", illegal, 1'b1);
        end
    endtask

    task automatic stream_and_hold();
        for (int k = 0; k < 16; k++) begin
            @(negedge clk);
            if (k > 0) begin
                bit_check("dec_valid", dec_valid, 1'b1);
                fields_check();    // word from the previous cycle
            end
            if ($urandom_range(0, 1) == 1)
                build_r($urandom_range(0, 35));
            else
                build_i($urandom_range(0, 23), $urandom_range(0, 1) == 1);
            inst       = word;
            inst_valid = 1'b1;
        end
        @(negedge clk);
        bit_check("dec_valid", dec_valid, 1'b1);
        fields_check();
        inst_valid = 1'b0;
        inst       = $urandom();
        repeat (2) begin
            @(negedge clk);
            bit_check("dec_valid", dec_valid, 1'b0);
            fields_check();
        end
    endtask

    initial begin
        repeat (LIMIT_CYC) @(posedge clk);
        $display("timeout: directed tests did not finish within %0d cycles", LIMIT_CYC);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        err_count  = 0;
        arst_n     = 1'b0;
        inst_valid = 1'b0;
        inst       = 32'h0000_0000;
        void'($urandom(32'h1a3c_56ae));
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        reset_state();
        rtype_sweep();
        itype_sweep();
        illegal_words();
        stream_and_hold();
        if (err_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+logic
logic/mips_pkg.sv
logic/decode_if.sv
logic/id_r.sv
logic/id_i.sv
logic/id_merge.sv
logic/id_stage.sv
test/tb_clock.sv
test/id_stage_tb.sv

// File: Makefile
SIM   = verilator
FLAGS = --binary --timing --timescale 1ns/1ps
TOP   = id_stage_tb
FLIST = files.f
MDIR  = obj_dir
LOG   = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(MDIR)
	./$(MDIR)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(MDIR) $(LOG)
